// ==== source/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_id_t;
  typedef logic [7:0]  imem_addr_t;  // word address
  typedef logic [7:0]  dmem_addr_t;  // word address
  typedef logic [2:0]  alu_op_t;

  typedef enum logic {
    LOADING,
    RUNNING
  } run_state_e;

  localparam int IMEM_DEPTH = 256;
  localparam int DMEM_DEPTH = 256;

  // major opcodes, rv32i encoding
  localparam logic [6:0] OPC_RTYPE  = 7'b0110011;
  localparam logic [6:0] OPC_ITYPE  = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  localparam alu_op_t ALU_ADD   = 3'd0;
  localparam alu_op_t ALU_SUB   = 3'd1;
  localparam alu_op_t ALU_AND   = 3'd2;
  localparam alu_op_t ALU_OR    = 3'd3;
  localparam alu_op_t ALU_XOR   = 3'd4;
  localparam alu_op_t ALU_SLT   = 3'd5;  // signed compare
  localparam alu_op_t ALU_PASSB = 3'd6;  // lui

endpackage

`default_nettype wire

// ==== source/pipe_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface decode_exec_if import cpu_pkg::*; ();
  word_t   pc;
  word_t   read1_data;
  word_t   read2_data;
  word_t   imm;
  reg_id_t rs1;
  reg_id_t rs2;
  reg_id_t rd;
  alu_op_t alu_op;
  logic    use_imm;
  logic    reg_write;
  logic    mem_read;
  logic    mem_write;
  logic    is_branch;
  logic    branch_ne;

  modport decode_side (
    output pc, read1_data, read2_data, imm, rs1, rs2, rd, alu_op,
    output use_imm, reg_write, mem_read, mem_write, is_branch, branch_ne
  );
  modport exec_side (
    input pc, read1_data, read2_data, imm, rs1, rs2, rd, alu_op,
    input use_imm, reg_write, mem_read, mem_write, is_branch, branch_ne
  );
endinterface

interface exec_result_if import cpu_pkg::*; ();
  word_t   alu_res;
  word_t   store_data;
  reg_id_t rd;
  logic    reg_write;
  logic    mem_read;
  logic    mem_write;

  modport exec_side (output alu_res, store_data, rd, reg_write, mem_read, mem_write);
  modport result_side (input alu_res, store_data, rd, reg_write, mem_read, mem_write);
endinterface

`default_nettype wire

// ==== source/instr_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_fetch import cpu_pkg::*; (
  input  logic       sys_clk,
  input  logic       rst_n,
  input  logic       start,
  input  logic       load_valid,
  input  imem_addr_t load_addr,
  input  word_t      load_data,
  input  logic       branch_taken,
  input  word_t      branch_pc,
  output word_t      instr,
  output word_t      pc
);

  run_state_e state;
  word_t      fetch_pc;  // address of the next read
  word_t      imem [IMEM_DEPTH];
  word_t      rd_word;
  logic       rd_ok;     // low inserts a bubble

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= LOADING;
      fetch_pc <= '0;
      pc       <= '0;
      rd_ok    <= 1'b0;
    end else begin
      case (state)
        LOADING: begin
          rd_ok <= 1'b0;
          if (start) begin
            state    <= RUNNING;
            fetch_pc <= '0;
          end
        end
        RUNNING: begin
          if (branch_taken) begin
            fetch_pc <= branch_pc;
            rd_ok    <= 1'b0;  // drop the wrong-path word
          end else begin
            fetch_pc <= fetch_pc + 32'd4;
            pc       <= fetch_pc;
            rd_ok    <= 1'b1;
          end
        end
      endcase
    end
  end

  // program load and synchronous read
  always_ff @(posedge sys_clk) begin
    if (load_valid && !start && state == LOADING) begin
      imem[load_addr] <= load_data;
    end
    rd_word <= imem[fetch_pc[9:2]];
  end

  assign instr = rd_ok ? rd_word : '0;  // all zero decodes as no-op

endmodule

`default_nettype wire

// ==== source/instr_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_decode import cpu_pkg::*; (
  input  logic    sys_clk,
  input  logic    rst_n,
  input  word_t   instr,
  input  word_t   pc,
  input  logic    branch_taken,
  input  logic    wb_valid,
  input  reg_id_t wb_id,
  input  word_t   wb_data,
  decode_exec_if.decode_side de
);

  word_t      regs [32];
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_id_t    rs1;
  reg_id_t    rs2;
  reg_id_t    rd;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm;
  word_t      read1;
  word_t      read2;
  alu_op_t    alu_op;
  logic       use_imm;
  logic       reg_write;
  logic       mem_read;
  logic       mem_write;
  logic       is_branch;

  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  always_comb begin
    alu_op    = ALU_ADD;
    imm       = imm_i;
    use_imm   = 1'b0;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    is_branch = 1'b0;
    case (opcode)
      OPC_RTYPE: begin
        reg_write = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: alu_op = ALU_ADD;
          {7'h20, 3'b000}: alu_op = ALU_SUB;
          {7'h00, 3'b111}: alu_op = ALU_AND;
          {7'h00, 3'b110}: alu_op = ALU_OR;
          {7'h00, 3'b100}: alu_op = ALU_XOR;
          {7'h00, 3'b010}: alu_op = ALU_SLT;
          default:         reg_write = 1'b0;  // unsupported
        endcase
      end
      OPC_ITYPE: begin
        use_imm   = 1'b1;
        reg_write = (funct3 == 3'b000);  // addi only
      end
      OPC_LUI: begin
        alu_op    = ALU_PASSB;
        imm       = imm_u;
        use_imm   = 1'b1;
        reg_write = 1'b1;
      end
      OPC_LOAD: begin
        use_imm   = 1'b1;
        reg_write = (funct3 == 3'b010);  // lw
        mem_read  = (funct3 == 3'b010);
      end
      OPC_STORE: begin
        imm       = imm_s;
        use_imm   = 1'b1;
        mem_write = (funct3 == 3'b010);  // sw
      end
      OPC_BRANCH: begin
        imm       = imm_b;
        is_branch = (funct3[2:1] == 2'b00);  // beq, bne
      end
      default: ;
    endcase
    if (rd == '0) begin
      reg_write = 1'b0;
    end
  end

  // write-through read, x0 reads zero
  assign read1 = (rs1 == '0) ? '0 : (wb_valid && wb_id == rs1) ? wb_data : regs[rs1];
  assign read2 = (rs2 == '0) ? '0 : (wb_valid && wb_id == rs2) ? wb_data : regs[rs2];

  always_ff @(posedge sys_clk) begin
    if (wb_valid && wb_id != '0) begin
      regs[wb_id] <= wb_data;
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      de.alu_op    <= ALU_ADD;
      de.use_imm   <= 1'b0;
      de.reg_write <= 1'b0;
      de.mem_read  <= 1'b0;
      de.mem_write <= 1'b0;
      de.is_branch <= 1'b0;
      de.branch_ne <= 1'b0;
    end else begin
      de.alu_op    <= alu_op;
      de.use_imm   <= use_imm;
      de.mem_read  <= mem_read;
      de.branch_ne <= funct3[0];
      de.reg_write <= reg_write && !branch_taken;  // flush on redirect
      de.mem_write <= mem_write && !branch_taken;
      de.is_branch <= is_branch && !branch_taken;
    end
  end

  always_ff @(posedge sys_clk) begin
    de.pc         <= pc;
    de.read1_data <= read1;
    de.read2_data <= read2;
    de.imm        <= imm;
    de.rs1        <= rs1;
    de.rs2        <= rs2;
    de.rd         <= rd;
  end

  a_no_x0_write: assert property (@(posedge sys_clk) disable iff (!rst_n)
    wb_valid |-> wb_id != '0);

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
  input  logic    sys_clk,
  input  logic    rst_n,
  decode_exec_if.exec_side de,
  input  logic    wb_valid,
  input  reg_id_t wb_id,
  input  word_t   wb_data,
  output logic    branch_taken,
  output word_t   branch_pc,
  exec_result_if.exec_side er
);

  logic  fwd1;
  logic  fwd2;
  word_t op1;
  word_t op2;
  word_t alu_b;
  word_t alu_res;

  // bypass from the result stage
  assign fwd1 = wb_valid && (wb_id != '0) && (wb_id == de.rs1);
  assign fwd2 = wb_valid && (wb_id != '0) && (wb_id == de.rs2);

  assign op1   = fwd1 ? wb_data : de.read1_data;
  assign op2   = fwd2 ? wb_data : de.read2_data;
  assign alu_b = de.use_imm ? de.imm : op2;

  always_comb begin
    case (de.alu_op)
      ALU_ADD:   alu_res = op1 + alu_b;
      ALU_SUB:   alu_res = op1 - alu_b;
      ALU_AND:   alu_res = op1 & alu_b;
      ALU_OR:    alu_res = op1 | alu_b;
      ALU_XOR:   alu_res = op1 ^ alu_b;
      ALU_SLT:   alu_res = {31'b0, $signed(op1) < $signed(alu_b)};
      ALU_PASSB: alu_res = alu_b;
      default:   alu_res = '0;
    endcase
  end

  // beq when branch_ne is low and bne when high
  assign branch_taken = de.is_branch && ((op1 == op2) != de.branch_ne);
  assign branch_pc    = de.pc + de.imm;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      er.reg_write <= 1'b0;
      er.mem_read  <= 1'b0;
      er.mem_write <= 1'b0;
    end else begin
      er.reg_write <= de.reg_write;
      er.mem_read  <= de.mem_read;
      er.mem_write <= de.mem_write;
    end
  end

  always_ff @(posedge sys_clk) begin
    er.alu_res    <= alu_res;
    er.store_data <= op2;  // forwarded rs2 for sw
    er.rd         <= de.rd;
  end

  // the slot behind a taken branch arrives flushed
  a_branch_flush: assert property (@(posedge sys_clk) disable iff (!rst_n)
    branch_taken |=> !(de.is_branch || de.reg_write || de.mem_write));

endmodule

`default_nettype wire

// ==== source/result_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module result_stage import cpu_pkg::*; (
  input  logic       sys_clk,
  input  logic       rst_n,
  exec_result_if.result_side er,
  output logic       wb_valid,
  output reg_id_t    wb_id,
  output word_t      wb_data,
  output logic       store_valid,
  output dmem_addr_t store_addr,
  output word_t      store_data
);

  word_t      dmem [DMEM_DEPTH];
  dmem_addr_t daddr;
  word_t      load_word;

  assign daddr     = er.alu_res[9:2];  // word index
  assign load_word = dmem[daddr];

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DMEM_DEPTH; i++) begin
        dmem[i] <= '0;
      end
    end else if (er.mem_write) begin
      dmem[daddr] <= er.store_data;
    end
  end

  // also the forwarding source for execute
  assign wb_valid = er.reg_write;
  assign wb_id    = er.rd;
  assign wb_data  = er.mem_read ? load_word : er.alu_res;

  assign store_valid = er.mem_write;
  assign store_addr  = daddr;
  assign store_data  = er.store_data;

  a_write_xor_store: assert property (@(posedge sys_clk) disable iff (!rst_n)
    !(er.mem_write && er.reg_write));

endmodule

`default_nettype wire

// ==== source/cpu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
  input  logic       sys_clk,
  input  logic       rst_n,
  input  logic       start,
  input  logic       load_valid,
  input  imem_addr_t load_addr,
  input  word_t      load_data,
  output logic       wb_valid,
  output reg_id_t    wb_id,
  output word_t      wb_data,
  output logic       store_valid,
  output dmem_addr_t store_addr,
  output word_t      store_data
);

  word_t instr;
  word_t pc;
  logic  branch_taken;
  word_t branch_pc;

  decode_exec_if de_bus ();
  exec_result_if er_bus ();

  instr_fetch u_fetch (
    .sys_clk      (sys_clk),
    .rst_n        (rst_n),
    .start        (start),
    .load_valid   (load_valid),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .branch_taken (branch_taken),
    .branch_pc    (branch_pc),
    .instr        (instr),
    .pc           (pc)
  );

  instr_decode u_decode (
    .sys_clk      (sys_clk),
    .rst_n        (rst_n),
    .instr        (instr),
    .pc           (pc),
    .branch_taken (branch_taken),
    .wb_valid     (wb_valid),
    .wb_id        (wb_id),
    .wb_data      (wb_data),
    .de           (de_bus)
  );

  execute_stage u_execute (
    .sys_clk      (sys_clk),
    .rst_n        (rst_n),
    .de           (de_bus),
    .wb_valid     (wb_valid),
    .wb_id        (wb_id),
    .wb_data      (wb_data),
    .branch_taken (branch_taken),
    .branch_pc    (branch_pc),
    .er           (er_bus)
  );

  result_stage u_result (
    .sys_clk     (sys_clk),
    .rst_n       (rst_n),
    .er          (er_bus),
    .wb_valid    (wb_valid),
    .wb_id       (wb_id),
    .wb_data     (wb_data),
    .store_valid (store_valid),
    .store_addr  (store_addr),
    .store_data  (store_data)
  );

endmodule

`default_nettype wire

// ==== tb/isa_model.svh ====
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

localparam word_t HALT_WORD = 32'h0000_0063;  // beq x0,x0,0

word_t      prog [IMEM_DEPTH];
int         plen;
word_t      m_regs [32];
word_t      m_mem [DMEM_DEPTH];
reg_id_t    exp_wr_id[$];
word_t      exp_wr_data[$];
dmem_addr_t exp_st_addr[$];
word_t      exp_st_data[$];

// r-type result straight from funct7/funct3
function automatic word_t alu_ref(input logic [6:0] f7, input logic [2:0] f3,
                                  input word_t a, input word_t b);
  case ({f7, f3})
    {7'h00, 3'b000}: return a + b;
    {7'h20, 3'b000}: return a - b;
    {7'h00, 3'b111}: return a & b;
    {7'h00, 3'b110}: return a | b;
    {7'h00, 3'b100}: return a ^ b;
    {7'h00, 3'b010}: return {31'b0, $signed(a) < $signed(b)};
    default:         return '0;
  endcase
endfunction

function automatic void model_write(input reg_id_t rd, input word_t v);
  if (rd != '0) begin
    m_regs[rd] = v;
    exp_wr_id.push_back(rd);
    exp_wr_data.push_back(v);
  end
endfunction

// runs prog in order until the final self-loop
function automatic void run_model();
  word_t ins;
  word_t a;
  word_t b;
  word_t addr;
  int    pc;
  int    next;
  int    steps;
  foreach (m_mem[i]) m_mem[i] = '0;
  m_regs[0] = '0;
  pc = 0;
  steps = 0;
  while (pc >= 0 && pc < plen && prog[pc] != HALT_WORD && steps < 20000) begin
    ins  = prog[pc];
    a    = m_regs[ins[19:15]];
    b    = m_regs[ins[24:20]];
    next = pc + 1;
    case (ins[6:0])
      OPC_RTYPE: model_write(ins[11:7], alu_ref(ins[31:25], ins[14:12], a, b));
      OPC_ITYPE: model_write(ins[11:7], a + {{20{ins[31]}}, ins[31:20]});
      OPC_LUI:   model_write(ins[11:7], {ins[31:12], 12'b0});
      OPC_LOAD: begin
        addr = a + {{20{ins[31]}}, ins[31:20]};
        model_write(ins[11:7], m_mem[addr[9:2]]);
      end
      OPC_STORE: begin
        addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        m_mem[addr[9:2]] = b;
        exp_st_addr.push_back(addr[9:2]);
        exp_st_data.push_back(b);
      end
      OPC_BRANCH: begin
        if ((a == b) != ins[12])
          next = pc + $signed({{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}) / 4;
      end
      default: ;
    endcase
    pc = next;
    steps++;
  end
endfunction

`endif

// ==== tb/cpu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

  logic       sys_clk;
  logic       rst_n;
  logic       start;
  logic       load_valid;
  imem_addr_t load_addr;
  word_t      load_data;
  logic       wb_valid;
  reg_id_t    wb_id;
  word_t      wb_data;
  logic       store_valid;
  dmem_addr_t store_addr;
  word_t      store_data;
  integer     seed = 32'h9a6c6eb7;

  `include "isa_model.svh"

  cpu_top uut (
    .sys_clk(sys_clk), .rst_n(rst_n), .start(start),
    .load_valid(load_valid), .load_addr(load_addr), .load_data(load_data),
    .wb_valid(wb_valid), .wb_id(wb_id), .wb_data(wb_data),
    .store_valid(store_valid), .store_addr(store_addr), .store_data(store_data)
  );

  initial begin
    sys_clk = 1'b0;
    forever #50 sys_clk = ~sys_clk;
  end

  task automatic check(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic fail_with(input string why);
    $display("ERROR: %s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  function automatic int pick(input int m);
    return {$random(seed)} % m;
  endfunction

  function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                  input reg_id_t rd, input reg_id_t rs1, input reg_id_t rs2);
    return {f7, rs2, rs1, f3, rd, OPC_RTYPE};
  endfunction

  function automatic word_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                  input reg_id_t rd, input reg_id_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(input reg_id_t rs2, input reg_id_t rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t enc_b(input logic ne, input reg_id_t rs1, input reg_id_t rs2,
                                  input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic void emit(input word_t w);
    prog[plen] = w;
    plen++;
  endfunction

  // every register gets a defined value first
  function automatic void emit_prologue();
    plen = 0;
    for (int i = 1; i < 32; i++) begin
      emit(enc_i(OPC_ITYPE, 3'b000, reg_id_t'(i), 5'd0, 12'(pick(4096))));
    end
  endfunction

  function automatic void build_alu_mem();
    emit_prologue();
    emit({20'habcde, 5'd5, OPC_LUI});
    emit(enc_i(OPC_ITYPE, 3'b000, 5, 5, 12'h123));  // distance one
    emit(enc_i(OPC_ITYPE, 3'b000, 6, 0, 12'hffb));  // -5
    emit(enc_i(OPC_ITYPE, 3'b000, 7, 0, 12'h003));
    emit(enc_r(7'h00, 3'b010, 8, 6, 7));
    emit(enc_r(7'h00, 3'b010, 9, 7, 6));
    emit(enc_r(7'h20, 3'b000, 10, 5, 6));
    emit(enc_r(7'h00, 3'b111, 11, 10, 5));
    emit(enc_r(7'h00, 3'b110, 12, 10, 11));  // distances two and one
    emit(enc_r(7'h00, 3'b100, 13, 12, 1));
    emit(enc_r(7'h00, 3'b000, 0, 13, 12));   // x0 target so no write
    emit(enc_r(7'h00, 3'b000, 14, 13, 0));
    emit(enc_s(13, 0, 12'd16));
    emit(enc_i(OPC_LOAD, 3'b010, 15, 0, 12'd16));
    emit(enc_r(7'h00, 3'b000, 16, 15, 15));  // load then use
    emit(enc_s(16, 0, 12'd20));
    emit(enc_i(OPC_LOAD, 3'b010, 17, 0, 12'd20));
    emit(enc_i(OPC_ITYPE, 3'b000, 18, 0, 12'd40));
    emit(enc_s(17, 18, 12'd4));
    emit(enc_i(OPC_LOAD, 3'b010, 19, 18, 12'd4));
    emit(HALT_WORD);
  endfunction

  function automatic void build_branches();
    emit_prologue();
    emit(enc_i(OPC_ITYPE, 3'b000, 20, 0, 12'd5));   // loop count
    emit(enc_i(OPC_ITYPE, 3'b000, 21, 0, 12'd0));
    emit(enc_i(OPC_ITYPE, 3'b000, 21, 21, 12'd3));
    emit(enc_i(OPC_ITYPE, 3'b000, 20, 20, 12'hfff));
    emit(enc_b(1'b1, 20, 0, 13'h1ff8));             // back two
    emit(enc_b(1'b0, 20, 0, 13'd12));
    emit(enc_i(OPC_ITYPE, 3'b000, 22, 0, 12'd1));   // skipped
    emit(enc_s(21, 0, 12'd0));                      // skipped
    emit(enc_i(OPC_ITYPE, 3'b000, 23, 0, 12'd7));
    emit(enc_b(1'b1, 0, 0, 13'd8));                 // not taken
    emit(enc_b(1'b0, 21, 0, 13'd8));                // not taken
    emit(enc_i(OPC_ITYPE, 3'b000, 24, 23, 12'd1));
    emit(enc_b(1'b0, 21, 21, 13'd8));
    emit(enc_s(24, 0, 12'd4));                      // skipped
    emit(enc_s(23, 0, 12'd8));
    emit(HALT_WORD);
  endfunction

  function automatic void build_random(input int count);
    int        end_idx;
    int        k;
    logic [6:0] f7;
    logic [2:0] f3;
    emit_prologue();
    end_idx = plen + count;
    while (plen < end_idx) begin
      case (pick(9))
        0, 1, 2: begin
          f7 = 7'h00;
          case (pick(6))
            0: f3 = 3'b000;
            1: begin
              f3 = 3'b000;
              f7 = 7'h20;
            end
            2: f3 = 3'b111;
            3: f3 = 3'b110;
            4: f3 = 3'b100;
            default: f3 = 3'b010;
          endcase
          emit(enc_r(f7, f3, reg_id_t'(pick(32)), reg_id_t'(pick(32)), reg_id_t'(pick(32))));
        end
        3: emit(enc_i(OPC_ITYPE, 3'b000, reg_id_t'(pick(32)), reg_id_t'(pick(32)),
                      12'(pick(4096))));
        4: emit({20'(pick(1 << 20)), reg_id_t'(pick(32)), OPC_LUI});
        5: emit(enc_i(OPC_LOAD, 3'b010, reg_id_t'(pick(32)), 0, 12'(pick(16) * 4)));
        6: emit(enc_s(reg_id_t'(pick(32)), 0, 12'(pick(16) * 4)));
        default: begin
          k = 2 + pick(3);  // forward only so the target stays inside the program
          if (plen + k <= end_idx)
            emit(enc_b(1'(pick(2)), reg_id_t'(pick(32)), reg_id_t'(pick(32)), 13'(k * 4)));
          else
            emit(enc_i(OPC_ITYPE, 3'b000, reg_id_t'(pick(32)), 0, 12'(pick(4096))));
        end
      endcase
    end
    emit(HALT_WORD);
  endfunction

  task automatic run_program(input string label);
    int cycles;
    rst_n      = 1'b0;
    start      = 1'b0;
    load_valid = 1'b0;
    repeat (16) @(posedge sys_clk);
    #5 rst_n = 1'b1;
    exp_wr_id.delete();
    exp_wr_data.delete();
    exp_st_addr.delete();
    exp_st_data.delete();
    run_model();
    for (int i = 0; i < plen; i++) begin
      @(posedge sys_clk);
      #5;
      load_valid = 1'b1;
      load_addr  = imem_addr_t'(i);
      load_data  = prog[i];
    end
    @(posedge sys_clk);
    #5;
    load_valid = 1'b0;
    start      = 1'b1;
    cycles = 0;
    while (exp_wr_id.size() != 0 || exp_st_addr.size() != 0) begin
      @(posedge sys_clk);
      cycles++;
      if (cycles > 5000) fail_with({"timeout, ", label, " did not finish its writes and stores"});
    end
    repeat (100) @(posedge sys_clk);  // any strobe here is caught as unexpected
    #5;
    $display("%s done", label);
  endtask

  initial begin
    forever begin
      @(negedge sys_clk);
      if (rst_n && wb_valid) begin
        if (exp_wr_id.size() == 0) begin
          fail_with("register write strobe seen when none was expected");
        end else begin
          check("wb_id", 32'(wb_id), 32'(exp_wr_id.pop_front()));
          check("wb_data", wb_data, exp_wr_data.pop_front());
        end
      end
    end
  end

  initial begin
    forever begin
      @(negedge sys_clk);
      if (rst_n && store_valid) begin
        if (exp_st_addr.size() == 0) begin
          fail_with("store strobe seen when none was expected");
        end else begin
          check("store_addr", 32'(store_addr), 32'(exp_st_addr.pop_front()));
          check("store_data", store_data, exp_st_data.pop_front());
        end
      end
    end
  end

  initial begin
    rst_n      = 1'b0;
    start      = 1'b0;
    load_valid = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    build_alu_mem();
    run_program("alu and memory program");
    build_branches();
    run_program("branch program");
    build_random(200);
    run_program("random program");
    build_alu_mem();
    run_program("reloaded program");
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+tb
source/cpu_pkg.sv
source/pipe_if.sv
source/instr_fetch.sv
source/instr_decode.sv
source/execute_stage.sv
source/result_stage.sv
source/cpu_top.sv
tb/cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module cpu_tb -f compile.f -o cpu_sim \
  && ./obj_dir/cpu_sim | tee /dev/stderr | grep -q "all tests passed" \
  && echo "simulation PASSED" \
  || { echo "simulation FAILED"; exit 1; }
